//--- bench/mipsCore_tests.txt
# T name illegalExpected | I wordIndex instruction | E pc regWrite dest data memWrite halted
# All numbers are hex; dest is compared only when regWrite is 1
T aluOps 0
I 00 20010005
I 01 2002FFFD
I 02 3043FF0F
I 03 34248000
I 04 2845FFFE
I 05 00223022
I 06 0041382A
I 07 00644024
I 08 00C14825
I 09 00225020
I 0A FC000000
E 00 1 01 00000005 0 0
E 04 1 02 FFFFFFFD 0 0
E 08 1 03 0000FF0D 0 0
E 0C 1 04 00008005 0 0
E 10 1 05 00000001 0 0
E 14 1 06 00000008 0 0
E 18 1 07 00000001 0 0
E 1C 1 08 00008005 0 0
E 20 1 09 0000000D 0 0
E 24 1 0A 00000002 0 0
E 28 0 00 00000000 0 1
T memBranch 0
I 00 20011234
I 01 AC010008
I 02 8C020008
I 03 10220001
I 05 14220001
I 06 14200001
I 08 10200001
I 09 FC000000
E 00 1 01 00001234 0 0
E 04 0 00 00001234 1 0
E 08 1 02 00001234 0 0
E 0C 0 00 00000000 0 0
E 14 0 00 00000000 0 0
E 18 0 00 00000000 0 0
E 20 0 00 00000000 0 0
E 24 0 00 00000000 0 1
T jumps 1
I 00 0C000003
I 01 08000004
I 03 03E00008
I 04 40000000
E 00 1 1F 00000004 0 0
E 0C 0 00 00000000 0 0
E 04 0 00 00000000 0 0
E 10 0 00 00000000 0 1

//--- mipsCore.f
+incdir+logic
logic/mipsPkg.sv
logic/control.sv
logic/alu.sv
logic/regFile.sv
logic/dataMem.sv
logic/mipsCore.sv
bench/mipsCore_properties.sv
bench/mipsCore_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the mipsCore testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module mipsCore_tb \
	-f mipsCore.f -Mdir obj_dir -o mipsCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

./obj_dir/mipsCoreSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -qx "Simulation passed" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

//--- bench/mipsCore_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mipsCore_tb;

	localparam int CommitTimeout = 50; // Cycles allowed per commit
	localparam int QuietCycles = 8;

	logic clk = 1'b0;
	logic rstN, imemWe, run;
	logic [`IMEM_AW-1:0] imemAddr;
	logic [`WORD_W-1:0] imemData;
	logic commitValid, halted, illegal;
	mipsPkg::commitT commit;

	string testName;
	logic illegalExp;
	logic [`IMEM_AW-1:0] addrQ [$];
	logic [`WORD_W-1:0] wordQ [$];
	mipsPkg::commitT expQ [$];
	int testErrors, testCount, failCount;

	mipsCore mipsCore_inst (.clk(clk), .rstN(rstN), .imemWe(imemWe), .imemAddr(imemAddr),
		.imemData(imemData), .run(run), .commitValid(commitValid), .commit(commit),
		.halted(halted), .illegal(illegal));

	always #2 clk = ~clk;

	task automatic checkField(input string what, input logic [`WORD_W-1:0] gotV,
		input logic [`WORD_W-1:0] expV);
		if (gotV !== expV)
		begin
			$display("error %0t: test %s %s got %h expected %h", $time, testName, what,
				gotV, expV);
			testErrors++;
		end
	endtask

	task automatic waitCommit(output logic seen);
		int cycles;
		seen = 1'b0;
		cycles = 0;
		while (!seen && cycles < CommitTimeout)
		begin
			@(negedge clk);
			cycles++;
			seen = commitValid; // Stable between edges
		end
	endtask

	task automatic runTest();
		logic seen;
		int n;
		mipsPkg::commitT want;
		testErrors = 0;
		@(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		repeat (2) @(negedge clk);
		rstN = 1'b1;
		foreach (addrQ[i])
		begin
			imemWe = 1'b1;
			imemAddr = addrQ[i];
			imemData = wordQ[i];
			@(negedge clk);
		end
		imemWe = 1'b0;
		run = 1'b1;
		seen = 1'b1;
		for (n = 0; n < expQ.size() && seen; n++)
		begin
			waitCommit(seen);
			want = expQ[n];
			if (!seen)
			begin
				$display("Test %s timed out waiting for commit %0d", testName, n);
				testErrors++;
			end
			else
			begin
				checkField("pc", commit.pc, want.pc);
				checkField("regWrite", 32'(commit.regWrite), 32'(want.regWrite));
				if (want.regWrite)
					checkField("dest", 32'(commit.dest), 32'(want.dest));
				checkField("data", commit.data, want.data);
				checkField("memWrite", 32'(commit.memWrite), 32'(want.memWrite));
				checkField("halted flag", 32'(commit.halted), 32'(want.halted));
			end
		end
		if (seen)
		begin
			repeat (QuietCycles)
			begin
				@(negedge clk);
				if (commitValid)
				begin
					$display("error %0t: test %s commit after halt", $time, testName);
					testErrors++;
				end
			end
			checkField("halted", 32'(halted), 32'd1);
			checkField("illegal", 32'(illegal), 32'(illegalExp));
		end
		run = 1'b0;
		testCount++;
		if (testErrors == 0)
			$display("test %s ok, %0d commits", testName, expQ.size());
		else
		begin
			$display("test %s failed with %0d errors", testName, testErrors);
			failCount++;
		end
	endtask

	initial
	begin
		int fd;
		string line, tag;
		logic [`WORD_W-1:0] f [0:5];
		mipsPkg::commitT expLine;
		rstN = 1'b1; // Pulled low at the start of each test
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		run = 1'b0;
		testCount = 0;
		failCount = 0;
		fd = $fopen("bench/mipsCore_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open bench/mipsCore_tests.txt");
			$display("Simulation failed");
			$finish;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				tag = "";
				void'($fgets(line, fd));
				void'($sscanf(line, "%s", tag)); // Comment lines give tag #
				if (tag == "T")
				begin
					if (testName != "")
						runTest();
					addrQ.delete();
					wordQ.delete();
					expQ.delete();
					void'($sscanf(line, "%s %s %h", tag, testName, f[0]));
					illegalExp = f[0][0];
				end
				else if (tag == "I")
				begin
					void'($sscanf(line, "%s %h %h", tag, f[0], f[1]));
					addrQ.push_back(f[0][`IMEM_AW-1:0]);
					wordQ.push_back(f[1]);
				end
				else if (tag == "E")
				begin
					void'($sscanf(line, "%s %h %h %h %h %h %h", tag, f[0], f[1], f[2], f[3],
						f[4], f[5]));
					expLine = '{pc: f[0], regWrite: f[1][0], dest: f[2][`REG_AW-1:0],
						data: f[3], memWrite: f[4][0], halted: f[5][0]};
					expQ.push_back(expLine);
				end
			end
			$fclose(fd);
			if (testName != "")
				runTest(); // Last test in the file
			$display("tests %0d, passed %0d, failed %0d", testCount, testCount - failCount,
				failCount);
			if (testCount > 0 && failCount == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/mipsCore_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mipsCore_properties (
	input logic clk,
	input logic rstN,
	input logic commitValid,
	input mipsPkg::commitT commit,
	input logic halted,
	input logic illegal,
	input logic [`WORD_W-1:0] r0Value
);

	// Register file contents, not the commit record
	noWriteToZero: assert property (@(posedge clk) disable iff (!rstN)
		commitValid |-> (r0Value == '0))
		else $error("Register r0 holds a nonzero value");

	// Halt commit itself lands in the cycle halted rises
	quietWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
		$past(halted) |-> !commitValid)
		else $error("Commit strobe seen while the core is halted");

	resetClears: assert property (@(posedge clk)
		($past(!rstN) && !rstN) |-> (!commitValid && !halted && !illegal))
		else $error("Outputs not cleared during reset");

endmodule

bind mipsCore mipsCore_properties mipsCore_propertiesInst (.clk(clk), .rstN(rstN),
	.commitValid(commitValid), .commit(commit), .halted(halted), .illegal(illegal),
	.r0Value(regFileInst.regs[0]));

`default_nettype wire

//--- logic/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module mipsCore (
	input  logic clk,
	input  logic rstN,
	input  logic imemWe,
	input  logic [`IMEM_AW-1:0] imemAddr,
	input  logic [`WORD_W-1:0] imemData,
	input  logic run,
	output logic commitValid,
	output mipsPkg::commitT commit,
	output logic halted,
	output logic illegal
);

	logic [`WORD_W-1:0] imem [0:`IMEM_DEPTH-1];
	logic [`WORD_W-1:0] pc, pcPlus4, nextPc, jumpTarget, branchTarget;
	logic [`WORD_W-1:0] signImm, extImm, opB;
	logic [`WORD_W-1:0] rsData, rtData, aluResult, memData, wbData;
	logic [`REG_AW-1:0] destReg;
	logic step, cond, regWe, commitWrite, illegalNow;
	mipsPkg::instrU instr;
	mipsPkg::ctrlT ctrl;

	assign instr = imem[pc[`IMEM_AW+1:2]];
	assign step  = run && !halted; // One retirement per edge

	// Program load only while stopped
	always_ff @(posedge clk)
	begin
		if (imemWe && !run)
			imem[imemAddr] <= imemData;
	end

	control controlInst (.opcode(instr.rFmt.opcode), .funct(instr.rFmt.funct), .ctrl(ctrl));

	assign signImm = {{16{instr.iFmt.imm16[15]}}, instr.iFmt.imm16};
	assign extImm  = ctrl.zeroExt ? {16'b0, instr.iFmt.imm16} : signImm;
	assign opB     = ctrl.aluSrc ? extImm : rtData;

	always_comb
	begin
		case (ctrl.regDst)
			2'b01:   destReg = instr.rFmt.rd;
			2'b10:   destReg = 5'd31; // Link register
			default: destReg = instr.rFmt.rt;
		endcase
	end

	assign regWe = ctrl.regWrite && step;

	regFile regFileInst (.clk(clk), .rstN(rstN), .rs(instr.rFmt.rs), .rt(instr.rFmt.rt),
		.we(regWe), .wa(destReg), .wd(wbData), .rsData(rsData), .rtData(rtData));

	alu aluInst (.aluOp(ctrl.aluOp), .funct(instr.rFmt.funct), .a(rsData), .b(opB),
		.result(aluResult), .cond(cond));

	dataMem dataMemInst (.clk(clk), .we(ctrl.memWrite && step), .addr(aluResult),
		.wd(rtData), .rd(memData));

	always_comb
	begin
		case (ctrl.memToReg)
			2'b01:   wbData = ctrl.memRead ? memData : '0;
			2'b10:   wbData = pcPlus4;
			default: wbData = aluResult;
		endcase
	end

	assign pcPlus4      = pc + 32'd4;
	assign jumpTarget   = {pcPlus4[31:28], instr.jFmt.target26, 2'b00};
	assign branchTarget = pcPlus4 + {signImm[29:0], 2'b00};

	always_comb
	begin
		if (ctrl.jump == 2'b01)
			nextPc = jumpTarget;
		else if (ctrl.jump == 2'b10)
			nextPc = rsData; // jr
		else if (ctrl.branch && cond)
			nextPc = branchTarget;
		else
			nextPc = pcPlus4;
	end

	assign illegalNow  = ctrl.illegal && (instr.rFmt.opcode != `HALT_OP);
	assign commitWrite = ctrl.regWrite && (destReg != '0); // Visible register change only

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pc          <= '0;
			halted      <= 1'b0;
			illegal     <= 1'b0;
			commitValid <= 1'b0;
		end
		else
		begin
			commitValid <= step;
			if (step)
			begin
				if (ctrl.illegal)
					halted <= 1'b1; // PC parks on the halting word
				else
					pc <= nextPc;
				illegal <= illegal || illegalNow;
			end
		end
	end

	// Data carries the writeback value, or the store value for sw
	always_ff @(posedge clk)
	begin
		if (step)
			commit <= '{pc: pc, regWrite: commitWrite, dest: destReg,
				data: commitWrite ? wbData : (ctrl.memWrite ? rtData : '0),
				memWrite: ctrl.memWrite, halted: ctrl.illegal};
	end

endmodule

`default_nettype wire

//--- logic/dataMem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module dataMem (
	input  logic clk,
	input  logic we,
	input  logic [`WORD_W-1:0] addr,
	input  logic [`WORD_W-1:0] wd,
	output logic [`WORD_W-1:0] rd
);

	logic [`WORD_W-1:0] mem [0:`DMEM_DEPTH-1];
	logic [`DMEM_AW-1:0] index;

	assign index = addr[`DMEM_AW+1:2]; // Byte address to word

	always_ff @(posedge clk)
	begin
		if (we)
			mem[index] <= wd;
	end

	assign rd = mem[index];

endmodule

`default_nettype wire

//--- logic/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module regFile (
	input  logic clk,
	input  logic rstN,
	input  logic [`REG_AW-1:0] rs,
	input  logic [`REG_AW-1:0] rt,
	input  logic we,
	input  logic [`REG_AW-1:0] wa,
	input  logic [`WORD_W-1:0] wd,
	output logic [`WORD_W-1:0] rsData,
	output logic [`WORD_W-1:0] rtData
);

	logic [`WORD_W-1:0] regs [0:(1 << `REG_AW)-1];

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			for (int i = 0; i < (1 << `REG_AW); i++)
				regs[i] <= '0;
		end
		else if (we && (wa != '0)) // r0 stays zero
			regs[wa] <= wd;
	end

	assign rsData = regs[rs];
	assign rtData = regs[rt];

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_defs.svh"

module alu (
	input  mipsPkg::aluOpT aluOp,
	input  logic [5:0] funct,
	input  logic [`WORD_W-1:0] a,
	input  logic [`WORD_W-1:0] b,
	output logic [`WORD_W-1:0] result,
	output logic cond
);

	logic [`WORD_W-1:0] sum;
	logic [`WORD_W-1:0] diff;
	logic [`WORD_W-1:0] lessThan;

	assign sum  = a + b;
	assign diff = a - b; // Also the compare for branches
	assign lessThan = {{(`WORD_W-1){1'b0}}, ($signed(a) < $signed(b))};

	always_comb
	begin
		result = '0;
		case (aluOp)
			mipsPkg::aluAdd: result = sum;
			mipsPkg::aluAnd: result = a & b;
			mipsPkg::aluOr:  result = a | b;
			mipsPkg::aluSlt: result = lessThan;
			mipsPkg::aluBeq, mipsPkg::aluBne: result = diff;
			mipsPkg::aluFunct:
			begin
				case (funct)
					6'b100010: result = diff;     // sub
					6'b100100: result = a & b;    // and
					6'b100101: result = a | b;    // or
					6'b101010: result = lessThan; // slt
					default:   result = sum;      // add, jr don't care
				endcase
			end
			default: result = '0; // Jumps and halt
		endcase
	end

	// Zero flag in the sense the branch wants
	always_comb
	begin
		case (aluOp)
			mipsPkg::aluBeq: cond = (diff == '0);
			mipsPkg::aluBne: cond = (diff != '0);
			default:         cond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/control.sv
`timescale 1ns/1ps
`default_nettype none

module control (
	input  logic [5:0] opcode,
	input  logic [5:0] funct,
	output mipsPkg::ctrlT ctrl
);

	always_comb
	begin
		// R format defaults
		ctrl.regDst   = 2'b01;
		ctrl.jump     = 2'b00;
		ctrl.branch   = 1'b0;
		ctrl.memRead  = 1'b0;
		ctrl.memToReg = 2'b00;
		ctrl.aluOp    = mipsPkg::aluFunct;
		ctrl.memWrite = 1'b0;
		ctrl.aluSrc   = 1'b0;
		ctrl.regWrite = 1'b1;
		ctrl.zeroExt  = 1'b0;
		ctrl.illegal  = 1'b0;

		case (opcode)
			6'b000000:
			begin
				if (funct == 6'b001000) // jr
				begin
					ctrl.jump     = 2'b10;
					ctrl.regWrite = 1'b0;
				end
			end
			6'b000010: // j
			begin
				ctrl.jump     = 2'b01;
				ctrl.aluOp    = mipsPkg::aluNone;
				ctrl.regWrite = 1'b0;
			end
			6'b000011: // jal
			begin
				ctrl.regDst   = 2'b10;
				ctrl.jump     = 2'b01;
				ctrl.memToReg = 2'b10; // Return address
				ctrl.aluOp    = mipsPkg::aluNone;
			end
			6'b001000: // addi
			begin
				ctrl.regDst = 2'b00;
				ctrl.aluOp  = mipsPkg::aluAdd;
				ctrl.aluSrc = 1'b1;
			end
			6'b001100: // andi
			begin
				ctrl.regDst  = 2'b00;
				ctrl.aluOp   = mipsPkg::aluAnd;
				ctrl.aluSrc  = 1'b1;
				ctrl.zeroExt = 1'b1;
			end
			6'b001101: // ori
			begin
				ctrl.regDst  = 2'b00;
				ctrl.aluOp   = mipsPkg::aluOr;
				ctrl.aluSrc  = 1'b1;
				ctrl.zeroExt = 1'b1;
			end
			6'b001010: // slti
			begin
				ctrl.regDst = 2'b00;
				ctrl.aluOp  = mipsPkg::aluSlt;
				ctrl.aluSrc = 1'b1;
			end
			6'b000100, 6'b000101: // beq, bne
			begin
				ctrl.branch   = 1'b1;
				ctrl.aluOp    = opcode[0] ? mipsPkg::aluBne : mipsPkg::aluBeq;
				ctrl.regWrite = 1'b0;
			end
			6'b100011: // lw
			begin
				ctrl.regDst   = 2'b00;
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 2'b01;
				ctrl.aluOp    = mipsPkg::aluAdd;
				ctrl.aluSrc   = 1'b1;
			end
			6'b101011: // sw
			begin
				ctrl.aluOp    = mipsPkg::aluAdd;
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b0;
			end
			default: // Halt marker and anything undecoded
			begin
				ctrl.aluOp    = mipsPkg::aluNone;
				ctrl.regWrite = 1'b0;
				ctrl.illegal  = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/mipsPkg.sv
`default_nettype none

`include "mips_defs.svh"

package mipsPkg;

	typedef enum logic [2:0] {
		aluAdd   = 3'b000,
		aluFunct = 3'b001, // Operation taken from funct
		aluAnd   = 3'b010,
		aluOr    = 3'b011,
		aluBeq   = 3'b100,
		aluBne   = 3'b101,
		aluSlt   = 3'b110,
		aluNone  = 3'b111
	} aluOpT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [`REG_AW-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmtT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [`REG_AW-1:0] rs;
		logic [`REG_AW-1:0] rt;
		logic [15:0] imm16;
	} iFmtT;

	typedef struct packed {
		logic [5:0] opcode;
		logic [25:0] target26;
	} jFmtT;

	// One fetched word, decoded per format
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
		jFmtT jFmt;
	} instrU;

	typedef struct packed {
		logic [1:0] regDst;   // 00 rt, 01 rd, 10 ra
		logic [1:0] jump;     // 00 none, 01 target, 10 register
		logic branch;
		logic memRead;
		logic [1:0] memToReg; // 00 ALU, 01 memory, 10 PC+4
		aluOpT aluOp;
		logic memWrite;
		logic aluSrc;         // Immediate as operand B
		logic regWrite;
		logic zeroExt;        // Immediate zero extended
		logic illegal;        // Halt or undecoded opcode
	} ctrlT;

	typedef struct packed {
		logic [`WORD_W-1:0] pc;
		logic regWrite;
		logic [`REG_AW-1:0] dest;
		logic [`WORD_W-1:0] data;
		logic memWrite;
		logic halted;
	} commitT;

endpackage

`default_nettype wire

//--- logic/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// Data path width
`define WORD_W 32

// Instruction memory, words and index width
`define IMEM_DEPTH 64
`define IMEM_AW 6

// Data memory, words and index width
`define DMEM_DEPTH 64
`define DMEM_AW 6

// Register specifier width
`define REG_AW 5

// Opcode reserved as the end of a program
`define HALT_OP 6'b111111

`endif
